//--- src.f
+incdir+common
common/predecPkg.sv
predecode/halfwordBoundary.sv
predecode/branchFinder.sv
src/redirectSelect.sv
src/branchPredecoder.sv
sim/tbBranchPredecoder.sv

//--- Bender.yml
package:
  name: branch_predecoder

sources:
  - include_dirs:
      - common
    files:
      - common/predecPkg.sv
      - predecode/halfwordBoundary.sv
      - predecode/branchFinder.sv
      - src/redirectSelect.sv
      - src/branchPredecoder.sv
      - target: simulation
        files:
          - sim/tbBranchPredecoder.sv

//--- sim/tbBranchPredecoder.sv
`timescale 1ns/1ns
`include "predec_params.svh"

module tbBranchPredecoder;
    import predecPkg::*;

    localparam int NUM_DIRECTED = 22;
    localparam int NUM_RANDOM = 300;
    localparam int MAX_CYCLES = 4 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    typedef struct packed {
        redirect_t redir;
        btUpdate_t upd;
        logic      carryValid;
    } expect_t;

    logic clk;
    logic rst;
    logic accept;
    logic clear;
    fetchOp_t op;
    logic [`PREDEC_NUM_HALF-1:0][15:0] instrs;
    redirect_t redirect;
    btUpdate_t btUpdate;

    // Reference copy of the split-instruction carry
    logic mCarryValid;
    logic [15:0] mCarryHalf;
    logic [31:0] mCarryPc;

    redirect_t expRedir;
    btUpdate_t expUpdNext;
    btUpdate_t expUpdCur;
    fetchId_t fetchTag;
    integer seed;
    int cycles;
    int checks;
    int errors;
    int tests;
    int testsFailed;
    int testErrBase;

    branchPredecoder branchPredecoder_i (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .clear    (clear),
        .op       (op),
        .instrs   (instrs),
        .redirect (redirect),
        .btUpdate (btUpdate)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Immediates as laid out in the RISC-V ISA
    function automatic logic [31:0] jalOffset(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] branchOffset(input logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] cjOffset(input logic [15:0] h);
        return {{20{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    endfunction

    function automatic logic [31:0] cbOffset(input logic [15:0] h);
        return {{23{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
    endfunction

    function automatic expect_t expectedOutcome(input fetchOp_t o,
            input logic [`PREDEC_NUM_HALF-1:0][15:0] h, input logic cValid,
            input logic [15:0] cHalf, input logic [31:0] cPc, input logic acc, input logic clr);
        expect_t e;
        logic [`PREDEC_NUM_HALF-1:0] s16;
        logic [`PREDEC_NUM_HALF-1:0] s32;
        logic carryStart;
        logic isJmp;
        logic isBr;
        logic isCall;
        logic compr;
        logic done;
        logic [31:0] base;
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] w;
        int startOffs;
        int lastValid;
        int pos;
        e = '0;
        s16 = '0;
        s32 = '0;
        done = 1'b0;
        startOffs = o.pc[3:1];
        lastValid = o.lastValid;
        base = {o.pc[31:4], 4'b0000};
        // A live carry completes at offset 0 and pulls the walk back to 0
        carryStart = cValid && startOffs == 0;
        pos = cValid ? 0 : startOffs;
        if (carryStart)
            pos = 1;
        while (pos <= lastValid) begin
            if (h[pos][1:0] == 2'b11) begin
                s32[pos] = 1'b1;
                pos = pos + 2;
            end else begin
                s16[pos] = 1'b1;
                pos = pos + 1;
            end
        end
        // Candidates sit at the offset of their final halfword
        for (int k = startOffs; k <= lastValid && !done; k++) begin
            isJmp = 1'b0;
            isBr = 1'b0;
            isCall = 1'b0;
            compr = 1'b0;
            target = '0;
            if (s16[k] && h[k][1:0] == 2'b01) begin
                compr = 1'b1;
                pc = base + 32'(2 * k);
                isJmp = h[k][15:13] == 3'b001 || h[k][15:13] == 3'b101;
                isCall = h[k][15:13] == 3'b001;
                isBr = h[k][15:14] == 2'b11;
                target = pc + (isJmp ? cjOffset(h[k]) : cbOffset(h[k]));
            end else if ((k == 0 && carryStart) || (k > 0 && s32[k - 1])) begin
                if (k == 0) begin
                    w = {h[0], cHalf};
                    pc = cPc;
                end else begin
                    w = {h[k], h[k - 1]};
                    pc = base + 32'(2 * (k - 1));
                end
                isJmp = w[6:0] == 7'h6f;
                isCall = isJmp && (w[11:7] == 5'd1 || w[11:7] == 5'd5);
                isBr = w[6:0] == 7'h63 && w[14:13] != 2'b01;
                target = pc + (isJmp ? jalOffset(w) : branchOffset(w));
            end
            if (o.predTaken && k == o.predPos) begin
                done = 1'b1;
                if (!(isJmp || isBr) || target[31:1] != o.predTarget) begin
                    e.redir.taken = 1'b1;
                    e.redir.fetchId = o.fetchId;
                    e.redir.endOffsValid = 1'b1;
                    if (s32[k]) begin
                        e.redir.dst = {o.pc[31:4], o.predPos};
                        e.redir.endOffs = o.predPos;
                    end else begin
                        e.redir.dst = {o.pc[31:4], o.predPos} + 31'd1;
                        e.redir.endOffs = o.predPos + 1'b1;
                        e.redir.endOffsValid = k != `PREDEC_NUM_HALF - 1;
                        if (k == `PREDEC_NUM_HALF - 1)
                            e.redir.endOffs = '0;
                    end
                    e.upd.valid = 1'b1;
                    e.upd.clean = 1'b1;
                    e.upd.src = {o.pc[31:4], o.predPos, 1'b0};
                    e.upd.fetchStartOffs = fetchOff_t'(startOffs);
                end
            end else if (isJmp) begin
                done = 1'b1;
                e.redir.taken = 1'b1;
                e.redir.fetchId = o.fetchId;
                e.redir.dst = target[31:1];
                if (k != `PREDEC_NUM_HALF - 1) begin
                    e.redir.endOffs = fetchOff_t'(k + 1);
                    e.redir.endOffsValid = 1'b1;
                end
                e.upd.valid = 1'b1;
                e.upd.isCall = isCall;
                e.upd.isJump = 1'b1;
                e.upd.compressed = compr;
                e.upd.src = base + 32'(2 * k);
                e.upd.dst = target;
                e.upd.fetchStartOffs = fetchOff_t'(startOffs);
            end
        end
        if (!acc)
            e.redir = '0;
        if (!acc || clr)
            e.upd = '0;
        if (clr)
            e.carryValid = 1'b0;
        else if (acc)
            e.carryValid = s32[lastValid] && !e.redir.taken;
        else
            e.carryValid = cValid;
        return e;
    endfunction

    function automatic fetchOp_t makeOp(input logic [31:0] pc, input int lastValid,
            input logic predTaken, input int predPos, input logic [31:0] predTarget);
        fetchOp_t o;
        o = '0;
        o.pc = pc;
        o.lastValid = fetchOff_t'(lastValid);
        o.predTaken = predTaken;
        o.predPos = fetchOff_t'(predPos);
        o.predTarget = predTarget[31:1];
        return o;
    endfunction

    task automatic applyPackage(input fetchOp_t o, input logic [`PREDEC_NUM_HALF-1:0][15:0] h,
            input logic acc, input logic clr);
        expect_t e;
        @(posedge clk);
        #1;
        o.fetchId = fetchTag;
        fetchTag = fetchTag + 1'b1;
        op = o;
        instrs = h;
        accept = acc;
        clear = clr;
        e = expectedOutcome(o, h, mCarryValid, mCarryHalf, mCarryPc, acc, clr);
        expRedir = e.redir;
        expUpdNext = e.upd;
        if (acc) begin
            mCarryHalf = h[o.lastValid];
            mCarryPc = {o.pc[31:4], o.lastValid, 1'b0};
        end
        mCarryValid = e.carryValid;
    endtask

    // One idle cycle lets the last update reach the checker
    task automatic finishTest(input string name);
        applyPackage(makeOp(32'h0, 7, 1'b0, 0, 32'h0), {8{16'h0001}}, 1'b0, 1'b0);
        @(negedge clk);
        #1;
        tests++;
        if (errors == testErrBase) begin
            $display("test %-10s ok", name);
        end else begin
            testsFailed++;
            $display("test %-10s FAILED with %0d errors", name, errors - testErrBase);
        end
        testErrBase = errors;
    endtask

    task automatic runRandom(input int count);
        logic [`PREDEC_NUM_HALF-1:0][15:0] h;
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] nextBase;
        int k;
        int startOffs;
        int lastValid;
        nextBase = 32'h0000_4000;
        for (int n = 0; n < count; n++) begin
            h = '0;
            k = 0;
            while (k < `PREDEC_NUM_HALF) begin
                r = $random(seed);
                w = '0;
                case (r[31:29])
                    3'd0: h[k] = {3'b101, r[10:0], 2'b01};
                    3'd1: h[k] = {3'b001, r[10:0], 2'b01};
                    3'd2: h[k] = {2'b11, r[11:0], 2'b01};
                    3'd3: w = {r[24:0], 7'h6f};
                    3'd4: w = {r[24:0], 7'h63};
                    3'd5: h[k] = {r[15:2], 2'b00};
                    3'd6: h[k] = {r[15:2], 2'b10};
                    default: w = {r[24:0], 7'h13};
                endcase
                if (w != '0) begin
                    // The upper half is lost when the word starts in the last slot
                    h[k] = w[15:0];
                    if (k < `PREDEC_NUM_HALF - 1)
                        h[k + 1] = w[31:16];
                    k = k + 2;
                end else begin
                    k = k + 1;
                end
            end
            r = $random(seed);
            startOffs = r[3] ? 0 : int'(r[2:0]);
            pc = r[3] ? nextBase : {r[31:20], 16'h0000, 4'b0000};
            pc = pc | 32'(startOffs * 2);
            lastValid = startOffs + int'(r[6:4]) % (`PREDEC_NUM_HALF - startOffs);
            w = $random(seed);
            applyPackage(makeOp(pc, lastValid, r[9:7] < 3'd3, int'(r[12:10]), w), h,
                         r[15:13] != 3'd0, r[19:16] == 4'd0);
            nextBase = {pc[31:4], 4'b0000} + 32'd16;
        end
    endtask

    always @(posedge clk) begin
        expUpdCur <= expUpdNext;
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checks += 2;
            assert (redirect === expRedir) else begin
                $display("ERROR t=%0t redirect: got %h expected %h", $time, redirect, expRedir);
                errors++;
            end
            if (expUpdCur.valid) begin
                assert (btUpdate === expUpdCur) else begin
                    $display("ERROR t=%0t btUpdate: got %h expected %h",
                             $time, btUpdate, expUpdCur);
                    errors++;
                end
            end else begin
                assert (btUpdate.valid === 1'b0) else begin
                    $display("ERROR t=%0t btUpdate.valid: got %b expected 0",
                             $time, btUpdate.valid);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [`PREDEC_NUM_HALF-1:0][15:0] h;
        rst = 1'b1;
        accept = 1'b0;
        clear = 1'b0;
        op = '0;
        instrs = '0;
        seed = 32'h48c15602;
        fetchTag = '0;
        mCarryValid = 1'b0;
        mCarryHalf = '0;
        mCarryPc = '0;
        expRedir = '0;
        expUpdNext = '0;
        expUpdCur = '0;
        cycles = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        testsFailed = 0;
        testErrBase = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        // Jumps offered with accept low
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), {8{16'h2011}}, 1'b0, 1'b0);
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), {8{16'hA019}}, 1'b0, 1'b0);
        finishTest("reset");

        h = {8{16'h0001}};
        h[2] = 16'hA019;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[3] = 16'h006F;
        h[4] = 16'h0100;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[0] = 16'h00EF;
        h[1] = 16'h0200;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[7] = 16'h2011;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[5] = 16'hF06F;
        h[6] = 16'hFF9F;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        finishTest("jumps");

        // Conditional branches, unpredicted and correctly predicted
        h = {8{16'h0001}};
        h[1] = 16'hC011;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        applyPackage(makeOp(32'h1000, 7, 1'b1, 1, 32'h1006), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[2] = 16'h0463;
        h[3] = 16'h0000;
        applyPackage(makeOp(32'h1000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        applyPackage(makeOp(32'h1000, 7, 1'b1, 3, 32'h100C), h, 1'b1, 1'b0);
        finishTest("branches");

        applyPackage(makeOp(32'h1000, 7, 1'b1, 4, 32'h1200), {8{16'h0001}}, 1'b1, 1'b0);
        applyPackage(makeOp(32'h1000, 7, 1'b1, 7, 32'h1200), {8{16'h0001}}, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[1] = 16'hC011;
        applyPackage(makeOp(32'h1000, 7, 1'b1, 1, 32'h1100), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[2] = 16'h0463;
        h[3] = 16'h0000;
        applyPackage(makeOp(32'h1000, 7, 1'b1, 2, 32'h100C), h, 1'b1, 1'b0);
        finishTest("mispredict");

        // jal split over two packages, then the same with a flush between
        h = {8{16'h0001}};
        h[7] = 16'h006F;
        applyPackage(makeOp(32'h2000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[0] = 16'h0100;
        applyPackage(makeOp(32'h2010, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        h = {8{16'h0001}};
        h[7] = 16'h006F;
        applyPackage(makeOp(32'h2000, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        applyPackage(makeOp(32'h2000, 7, 1'b0, 0, 32'h0), h, 1'b0, 1'b1);
        h = {8{16'h0001}};
        h[0] = 16'h0100;
        applyPackage(makeOp(32'h2010, 7, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        finishTest("split");

        h = {8{16'h0001}};
        h[1] = 16'hA019;
        h[6] = 16'hA019;
        h[7] = 16'h2011;
        applyPackage(makeOp(32'h3006, 5, 1'b0, 0, 32'h0), h, 1'b1, 1'b0);
        applyPackage(makeOp(32'h3000, 7, 1'b0, 0, 32'h0), h, 1'b0, 1'b0);
        finishTest("window");

        runRandom(NUM_RANDOM);
        finishTest("random");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src/branchPredecoder.sv
`timescale 1ns/1ns
`include "predec_params.svh"

module branchPredecoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               accept,
    input  logic                               clear,
    input  predecPkg::fetchOp_t                op,
    input  logic [`PREDEC_NUM_HALF-1:0][15:0]  instrs,
    output predecPkg::redirect_t               redirect,
    output predecPkg::btUpdate_t               btUpdate
);
    import predecPkg::*;

    boundary_t boundary;
    carry_t carry;
    branchInfo_t [`PREDEC_NUM_HALF-1:0] branches;

    halfwordBoundary halfwordBoundary_i (
        .clk        (clk),
        .rst        (rst),
        .accept     (accept),
        .clear      (clear),
        .op         (op),
        .instrs     (instrs),
        .redirTaken (redirect.taken),
        .boundary   (boundary),
        .carry      (carry)
    );

    branchFinder branchFinder_i (
        .op       (op),
        .instrs   (instrs),
        .boundary (boundary),
        .carry    (carry),
        .branches (branches)
    );

    redirectSelect redirectSelect_i (
        .clk      (clk),
        .accept   (accept),
        .clear    (clear),
        .op       (op),
        .boundary (boundary),
        .branches (branches),
        .redirect (redirect),
        .btUpdate (btUpdate)
    );

endmodule

//--- src/redirectSelect.sv
`timescale 1ns/1ns
`include "predec_params.svh"

module redirectSelect (
    input  logic                                           clk,
    input  logic                                           accept,
    input  logic                                           clear,
    input  predecPkg::fetchOp_t                            op,
    input  predecPkg::boundary_t                           boundary,
    input  predecPkg::branchInfo_t [`PREDEC_NUM_HALF-1:0]  branches,
    output predecPkg::redirect_t                           redirect,
    output predecPkg::btUpdate_t                           btUpdate
);
    import predecPkg::*;

    redirect_t redirNext;
    btUpdate_t updNext;
    fetchOff_t startOffs;
    logic [`PREDEC_OFFS_W:0] predSlot;
    logic [`PREDEC_ADDR_W-2:0] predHw;
    logic predIllegal;
    logic fhMisplaced;

    assign startOffs = op.pc[1 +: `PREDEC_OFFS_W];
    assign predSlot = {1'b0, op.predPos} + 1'b1;
    assign predHw = {op.pc[`PREDEC_ADDR_W-1:`PREDEC_OFFS_W+1], op.predPos};

    // Predicted on the first half of a 32-bit instruction
    assign predIllegal = boundary.is32[predSlot];

    always_comb begin
        logic done;
        fetchOff_t offs;
        fetchOff_t fhOffs;
        branchInfo_t br;
        redirNext = '0;
        updNext = '0;
        done = 1'b0;
        for (int i = 0; i < `PREDEC_NUM_HALF; i++) begin
            offs = fetchOff_t'(i);
            br = branches[i];
            fhOffs = br.fhPc[1 +: `PREDEC_OFFS_W];
            if (!done && offs >= startOffs && offs <= op.lastValid) begin
                if (op.predTaken && offs == op.predPos) begin
                    // A correct prediction also ends the scan
                    done = 1'b1;
                    if (!br.valid || br.target[`PREDEC_ADDR_W-1:1] != op.predTarget) begin
                        redirNext.taken = 1'b1;
                        redirNext.fetchId = op.fetchId;
                        if (predIllegal) begin
                            // Refetch the whole 32-bit instruction
                            redirNext.dst = predHw;
                            redirNext.endOffs = op.predPos;
                            redirNext.endOffsValid = 1'b1;
                        end else begin
                            redirNext.dst = predHw + 1'b1;
                            if (op.predPos != '1) begin
                                redirNext.endOffs = op.predPos + 1'b1;
                                redirNext.endOffsValid = 1'b1;
                            end
                        end
                        updNext.valid = 1'b1;
                        updNext.clean = 1'b1;
                        updNext.src = {predHw, 1'b0};
                        updNext.fetchStartOffs = startOffs;
                    end
                end else if (br.valid && (br.btype == JUMP || br.btype == CALL)) begin
                    // Unpredicted direct jump
                    done = 1'b1;
                    redirNext.taken = 1'b1;
                    redirNext.fetchId = op.fetchId;
                    redirNext.dst = br.target[`PREDEC_ADDR_W-1:1];
                    if (fhOffs != '1) begin
                        redirNext.endOffs = fhOffs + 1'b1;
                        redirNext.endOffsValid = 1'b1;
                    end
                    updNext.valid = 1'b1;
                    updNext.isCall = (br.btype == CALL);
                    updNext.isJump = 1'b1;
                    updNext.compressed = br.compr;
                    updNext.src = br.fhPc;
                    updNext.dst = br.target;
                    updNext.fetchStartOffs = startOffs;
                end
            end
        end
    end

    // Found branches must sit at the offset of their final halfword
    always_comb begin
        fhMisplaced = 1'b0;
        for (int i = 0; i < `PREDEC_NUM_HALF; i++) begin
            if (branches[i].valid &&
                    branches[i].fhPc[1 +: `PREDEC_OFFS_W] != fetchOff_t'(i)) begin
                fhMisplaced = 1'b1;
            end
        end
    end

    assign redirect = accept ? redirNext : '0;

    always_ff @(posedge clk) begin
        if (accept && !clear) begin
            btUpdate <= updNext;
        end else begin
            btUpdate.valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) accept |-> !fhMisplaced)
        else $error("branch info not indexed by the offset of its final halfword");

endmodule

//--- predecode/branchFinder.sv
`timescale 1ns/1ns
`include "predec_params.svh"

module branchFinder (
    input  predecPkg::fetchOp_t                            op,
    input  logic [`PREDEC_NUM_HALF-1:0][15:0]              instrs,
    input  predecPkg::boundary_t                           boundary,
    input  predecPkg::carry_t                              carry,
    output predecPkg::branchInfo_t [`PREDEC_NUM_HALF-1:0]  branches
);
    import predecPkg::*;

    logic [`PREDEC_NUM_HALF:0][15:0] instrsView;
    logic [`PREDEC_ADDR_W-1:0] basePc;
    logic [`PREDEC_NUM_HALF:0][`PREDEC_ADDR_W-1:0] slotPc;
    logic [`PREDEC_NUM_HALF:0][`PREDEC_ADDR_W-1:0] cjTarget;
    logic [`PREDEC_NUM_HALF:0][`PREDEC_ADDR_W-1:0] cbTarget;
    logic [`PREDEC_NUM_HALF-1:0][`PREDEC_ADDR_W-1:0] jTarget;
    logic [`PREDEC_NUM_HALF-1:0][`PREDEC_ADDR_W-1:0] bTarget;

    assign instrsView = {instrs, carry.halfword};
    assign basePc = {op.pc[`PREDEC_ADDR_W-1:`PREDEC_OFFS_W+1], {`PREDEC_OFFS_W{1'b0}}, 1'b0};

    always_comb begin
        slotPc[0] = carry.pc;
        for (int i = 1; i <= `PREDEC_NUM_HALF; i++) begin
            slotPc[i] = basePc + `PREDEC_ADDR_W'(2 * (i - 1));
        end
    end

    // Direct targets for every possible start slot
    always_comb begin
        logic [15:0] h;
        logic [31:0] w;
        for (int i = 0; i <= `PREDEC_NUM_HALF; i++) begin
            h = instrsView[i];
            cjTarget[i] = slotPc[i] + {{(`PREDEC_ADDR_W-12){h[12]}}, h[12], h[8], h[10:9],
                                       h[6], h[7], h[2], h[11], h[5:3], 1'b0};
            cbTarget[i] = slotPc[i] + {{(`PREDEC_ADDR_W-9){h[12]}}, h[12], h[6:5], h[2],
                                       h[11:10], h[4:3], 1'b0};
        end
        for (int i = 0; i < `PREDEC_NUM_HALF; i++) begin
            w = {instrsView[i+1], instrsView[i]};
            jTarget[i] = slotPc[i] + {{(`PREDEC_ADDR_W-21){w[31]}}, w[31], w[19:12], w[20],
                                      w[30:21], 1'b0};
            bTarget[i] = slotPc[i] + {{(`PREDEC_ADDR_W-13){w[31]}}, w[31], w[7], w[30:25],
                                      w[11:8], 1'b0};
        end
    end

    // Branches are indexed by the offset of their final halfword
    always_comb begin
        logic [15:0] h;
        logic [31:0] w;
        branches = '0;
        for (int i = 0; i < `PREDEC_NUM_HALF; i++) begin
            h = instrsView[i+1];
            if (boundary.is16[i+1] && h[1:0] == 2'b01) begin
                branches[i].compr = 1'b1;
                branches[i].pc = slotPc[i+1];
                branches[i].fhPc = slotPc[i+1];
                case (h[15:13])
                    // c.jal, c.j
                    3'b001, 3'b101: begin
                        branches[i].valid = 1'b1;
                        branches[i].btype = (h[15:13] == 3'b001) ? CALL : JUMP;
                        branches[i].target = cjTarget[i+1];
                    end
                    // c.beqz, c.bnez
                    3'b110, 3'b111: begin
                        branches[i].valid = 1'b1;
                        branches[i].btype = BRANCH;
                        branches[i].target = cbTarget[i+1];
                    end
                    default: ;
                endcase
            end
        end
        for (int i = 0; i < `PREDEC_NUM_HALF; i++) begin
            w = {instrsView[i+1], instrsView[i]};
            if (boundary.is32[i]) begin
                branches[i].compr = 1'b0;
                branches[i].pc = slotPc[i];
                branches[i].fhPc = slotPc[i+1];
                case (opcode_e'(w[6:0]))
                    OP_JAL: begin
                        branches[i].valid = 1'b1;
                        // Link register x1 or x5 means call
                        branches[i].btype = (w[11:7] == 5'd1 || w[11:7] == 5'd5) ? CALL : JUMP;
                        branches[i].target = jTarget[i];
                    end
                    OP_BRANCH: begin
                        // funct3 010 and 011 are reserved
                        if (w[14:13] != 2'b01) begin
                            branches[i].valid = 1'b1;
                            branches[i].btype = BRANCH;
                            branches[i].target = bTarget[i];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- predecode/halfwordBoundary.sv
`timescale 1ns/1ns
`include "predec_params.svh"

module halfwordBoundary (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                accept,
    input  logic                                clear,
    input  predecPkg::fetchOp_t                 op,
    input  logic [`PREDEC_NUM_HALF-1:0][15:0]   instrs,
    input  logic                                redirTaken,
    output predecPkg::boundary_t                boundary,
    output predecPkg::carry_t                   carry
);
    import predecPkg::*;

    logic [`PREDEC_NUM_HALF:0][15:0] instrsView;
    fetchOff_t startOffs;
    fetchOff_t firstValid;
    logic [`PREDEC_OFFS_W:0] lastSlot;
    logic [`PREDEC_ADDR_W-1:0] lastPc;

    logic carryValid;
    logic [15:0] carryHalf;
    logic [`PREDEC_ADDR_W-1:0] carryPc;

    assign instrsView = {instrs, carryHalf};
    assign startOffs = op.pc[1 +: `PREDEC_OFFS_W];
    assign firstValid = carryValid ? '0 : startOffs;
    assign lastSlot = {1'b0, op.lastValid} + 1'b1;
    assign lastPc = {op.pc[`PREDEC_ADDR_W-1:`PREDEC_OFFS_W+1], op.lastValid, 1'b0};

    // Walk the halfwords and mark instruction starts
    always_comb begin
        logic startOk;
        fetchOff_t offs;
        boundary = '0;
        startOk = 1'b1;
        // Carried first half completes at offset 0
        if (carryValid && startOffs == '0) begin
            boundary.is32[0] = 1'b1;
            startOk = 1'b0;
        end
        for (int i = 1; i <= `PREDEC_NUM_HALF; i++) begin
            offs = fetchOff_t'(i - 1);
            if (startOk && offs >= firstValid && offs <= op.lastValid) begin
                if (instrsView[i][1:0] == 2'b11) begin
                    boundary.is32[i] = 1'b1;
                    startOk = 1'b0;
                end else begin
                    boundary.is16[i] = 1'b1;
                end
            end else begin
                // Second half or outside the package
                startOk = 1'b1;
            end
        end
    end

    // A 32-bit start in the last valid halfword waits for its second half
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            carryValid <= 1'b0;
        end else if (accept) begin
            carryValid <= boundary.is32[lastSlot] && !redirTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            carryHalf <= instrs[op.lastValid];
            carryPc <= lastPc;
        end
    end

    assign carry = '{valid: carryValid, halfword: carryHalf, pc: carryPc};

    // The carried halfword always opens a 32-bit instruction
    assert property (@(posedge clk) disable iff (rst) carryValid |-> carryHalf[1:0] == 2'b11)
        else $error("carried halfword does not start a 32-bit instruction");

endmodule

//--- common/predecPkg.sv
`include "predec_params.svh"

package predecPkg;

    typedef logic [`PREDEC_OFFS_W-1:0] fetchOff_t;
    typedef logic [`PREDEC_FETCH_ID_W-1:0] fetchId_t;

    // One fetch package as delivered by the fetch stage
    typedef struct packed {
        logic [`PREDEC_ADDR_W-1:0] pc;
        fetchOff_t                 lastValid;
        fetchId_t                  fetchId;
        logic                      predTaken;
        fetchOff_t                 predPos;     // Final halfword of the predicted branch
        logic [`PREDEC_ADDR_W-2:0] predTarget;  // Halfword address
    } fetchOp_t;

    // Slot 0 is the carried halfword, slots 1..N are the package halfwords
    typedef struct packed {
        logic [`PREDEC_NUM_HALF:0] is16;
        logic [`PREDEC_NUM_HALF:0] is32;
    } boundary_t;

    typedef struct packed {
        logic                      valid;
        logic [15:0]               halfword;
        logic [`PREDEC_ADDR_W-1:0] pc;
    } carry_t;

    typedef enum logic [1:0] {
        JUMP,
        CALL,
        BRANCH
    } branchType_e;

    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic                      valid;
        logic                      compr;
        branchType_e               btype;
        logic [`PREDEC_ADDR_W-1:0] pc;
        logic [`PREDEC_ADDR_W-1:0] fhPc;
        logic [`PREDEC_ADDR_W-1:0] target;
    } branchInfo_t;

    typedef struct packed {
        logic                      taken;
        fetchId_t                  fetchId;
        logic [`PREDEC_ADDR_W-2:0] dst;
        fetchOff_t                 endOffs;
        logic                      endOffsValid;
    } redirect_t;

    typedef struct packed {
        logic                      valid;
        logic                      clean;
        logic                      isCall;
        logic                      isJump;
        logic                      compressed;
        logic [`PREDEC_ADDR_W-1:0] src;
        logic [`PREDEC_ADDR_W-1:0] dst;
        fetchOff_t                 fetchStartOffs;
    } btUpdate_t;

endpackage

//--- common/predec_params.svh
`ifndef PREDEC_PARAMS_SVH
`define PREDEC_PARAMS_SVH

// Halfwords per fetch package
`define PREDEC_NUM_HALF 8

// Width of a halfword offset inside a package, log2 of PREDEC_NUM_HALF
`define PREDEC_OFFS_W 3

// Instruction address width
`define PREDEC_ADDR_W 32

// Width of the fetch tag carried with each package
`define PREDEC_FETCH_ID_W 4

`endif
